// ==== id_pkg.sv ====
/*
  Shared widths, encodings and bundles of the RV32I decode/issue stage.
  Only the base integer opcodes kept by the stage are listed; all else decodes illegal.
*/
`default_nettype none

package id_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;

  // Sequential PC step without compressed instructions
  localparam logic [xlen-1:0] pc_incr = 32'd4;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    opc_load   = 7'h03,
    opc_op_imm = 7'h13,
    opc_auipc  = 7'h17,
    opc_store  = 7'h23,
    opc_op     = 7'h33,
    opc_lui    = 7'h37,
    opc_branch = 7'h63,
    opc_jal    = 7'h6f
  } opcode_e;

  // Arithmetic ops come first and the branch comparisons follow
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu,
    alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {
    op_a_reg  = 2'd0,
    op_a_pc   = 2'd1,
    op_a_zero = 2'd2
  } op_a_sel_e;

  typedef enum logic {
    op_b_reg = 1'b0,
    op_b_imm = 1'b1
  } op_b_sel_e;

  typedef enum logic [2:0] {
    imm_sel_itype, imm_sel_stype, imm_sel_btype, imm_sel_utype, imm_sel_jtype
  } imm_sel_e;

  // Access width as seen by the LSU
  typedef enum logic [1:0] {
    lsu_word = 2'b00,
    lsu_half = 2'b01,
    lsu_byte = 2'b10
  } lsu_type_e;

  ////////////////////
  // Bundles
  ////////////////////

  // Decoder output of 36 bits
  typedef struct packed {
    alu_op_e                alu_op;
    op_a_sel_e              op_a_sel;
    op_b_sel_e              op_b_sel;
    imm_sel_e               imm_sel;
    logic                   rf_we;
    logic [reg_addr_w-1:0]  rs1;
    logic [reg_addr_w-1:0]  rs2;
    logic [reg_addr_w-1:0]  rd;
    logic                   ren_a;
    logic                   ren_b;
    logic                   lsu_req;
    logic                   lsu_we;
    lsu_type_e              lsu_type;
    logic                   lsu_sign_ext;
    logic                   branch;
    logic                   jump;
  } ctrl_t;

  // Operator and operands of 69 bits to the execute unit
  typedef struct packed {
    alu_op_e          alu_op;
    logic [xlen-1:0]  operand_a;
    logic [xlen-1:0]  operand_b;
  } ex_req_t;

  // Data memory request of 37 bits
  typedef struct packed {
    logic             req;
    logic             we;
    lsu_type_e        data_type;
    logic             sign_ext;
    logic [xlen-1:0]  wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

// ==== id_decoder.sv ====
/*
  Purely combinational RV32I decode. JALR, fences, system, compressed, M and B
  encodings are all flagged illegal; an illegal word never writes, jumps or accesses memory.
*/
`default_nettype none

module id_decoder (
  input  logic [id_pkg::xlen-1:0] instr_i,
  output id_pkg::ctrl_t           ctrl_o,
  output logic                    illegal_o
);
  import id_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  ctrl_t      ctrl_raw;
  logic       illegal_raw;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////
  // Field decode
  ////////////////////

  always_comb begin
    ctrl_raw          = '0;
    ctrl_raw.alu_op   = alu_add;
    ctrl_raw.op_a_sel = op_a_reg;
    ctrl_raw.op_b_sel = op_b_reg;
    ctrl_raw.imm_sel  = imm_sel_itype;
    ctrl_raw.lsu_type = lsu_word;
    // Register fields sit at fixed positions in every format
    ctrl_raw.rs1      = instr_i[19:15];
    ctrl_raw.rs2      = instr_i[24:20];
    ctrl_raw.rd       = instr_i[11:7];
    illegal_raw       = 1'b0;

    unique case (opcode)
      opc_op: begin
        ctrl_raw.rf_we = 1'b1;
        ctrl_raw.ren_a = 1'b1;
        ctrl_raw.ren_b = 1'b1;
        // Only bit 30 may be set in funct7
        if ({funct7[6], funct7[4:0]} != 6'b0) begin
          illegal_raw = 1'b1;
        end
        unique case ({funct7[5], funct3})
          4'b0_000: ctrl_raw.alu_op = alu_add;
          4'b1_000: ctrl_raw.alu_op = alu_sub;
          4'b0_001: ctrl_raw.alu_op = alu_sll;
          4'b0_010: ctrl_raw.alu_op = alu_slt;
          4'b0_011: ctrl_raw.alu_op = alu_sltu;
          4'b0_100: ctrl_raw.alu_op = alu_xor;
          4'b0_101: ctrl_raw.alu_op = alu_srl;
          4'b1_101: ctrl_raw.alu_op = alu_sra;
          4'b0_110: ctrl_raw.alu_op = alu_or;
          4'b0_111: ctrl_raw.alu_op = alu_and;
          default:  illegal_raw     = 1'b1;
        endcase
      end

      opc_op_imm: begin
        ctrl_raw.rf_we    = 1'b1;
        ctrl_raw.ren_a    = 1'b1;
        ctrl_raw.op_b_sel = op_b_imm;
        unique case (funct3)
          3'b000: ctrl_raw.alu_op = alu_add;
          3'b010: ctrl_raw.alu_op = alu_slt;
          3'b011: ctrl_raw.alu_op = alu_sltu;
          3'b100: ctrl_raw.alu_op = alu_xor;
          3'b110: ctrl_raw.alu_op = alu_or;
          3'b111: ctrl_raw.alu_op = alu_and;
          3'b001: begin
            ctrl_raw.alu_op = alu_sll;
            illegal_raw     = (funct7 != 7'b0);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            ctrl_raw.alu_op = funct7[5] ? alu_sra : alu_srl;
            illegal_raw     = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end

      opc_lui: begin
        ctrl_raw.rf_we    = 1'b1;
        ctrl_raw.op_a_sel = op_a_zero;
        ctrl_raw.op_b_sel = op_b_imm;
        ctrl_raw.imm_sel  = imm_sel_utype;
      end

      opc_auipc: begin
        ctrl_raw.rf_we    = 1'b1;
        ctrl_raw.op_a_sel = op_a_pc;
        ctrl_raw.op_b_sel = op_b_imm;
        ctrl_raw.imm_sel  = imm_sel_utype;
      end

      opc_load: begin
        // Address is rs1 plus I-immediate
        ctrl_raw.rf_we        = 1'b1;
        ctrl_raw.ren_a        = 1'b1;
        ctrl_raw.op_b_sel     = op_b_imm;
        ctrl_raw.lsu_req      = 1'b1;
        ctrl_raw.lsu_sign_ext = ~funct3[2];
        unique case (funct3[1:0])
          2'b00:   ctrl_raw.lsu_type = lsu_byte;
          2'b01:   ctrl_raw.lsu_type = lsu_half;
          2'b10:   ctrl_raw.lsu_type = lsu_word;
          default: illegal_raw       = 1'b1;
        endcase
        // No unsigned word load in RV32
        if (funct3 == 3'b110) begin
          illegal_raw = 1'b1;
        end
      end

      opc_store: begin
        ctrl_raw.ren_a    = 1'b1;
        ctrl_raw.ren_b    = 1'b1;
        ctrl_raw.op_b_sel = op_b_imm;
        ctrl_raw.imm_sel  = imm_sel_stype;
        ctrl_raw.lsu_req  = 1'b1;
        ctrl_raw.lsu_we   = 1'b1;
        unique case (funct3)
          3'b000:  ctrl_raw.lsu_type = lsu_byte;
          3'b001:  ctrl_raw.lsu_type = lsu_half;
          3'b010:  ctrl_raw.lsu_type = lsu_word;
          default: illegal_raw       = 1'b1;
        endcase
      end

      opc_branch: begin
        // Execute compares the two registers and returns the decision
        ctrl_raw.branch  = 1'b1;
        ctrl_raw.ren_a   = 1'b1;
        ctrl_raw.ren_b   = 1'b1;
        ctrl_raw.imm_sel = imm_sel_btype;
        unique case (funct3)
          3'b000:  ctrl_raw.alu_op = alu_eq;
          3'b001:  ctrl_raw.alu_op = alu_ne;
          3'b100:  ctrl_raw.alu_op = alu_lt;
          3'b101:  ctrl_raw.alu_op = alu_ge;
          3'b110:  ctrl_raw.alu_op = alu_ltu;
          3'b111:  ctrl_raw.alu_op = alu_geu;
          default: illegal_raw     = 1'b1;
        endcase
      end

      opc_jal: begin
        // Execute sees pc plus J-immediate, its result goes to rd
        ctrl_raw.jump     = 1'b1;
        ctrl_raw.rf_we    = 1'b1;
        ctrl_raw.op_a_sel = op_a_pc;
        ctrl_raw.op_b_sel = op_b_imm;
        ctrl_raw.imm_sel  = imm_sel_jtype;
      end

      default: illegal_raw = 1'b1;
    endcase
  end

  ////////////////////
  // Illegal masking
  ////////////////////

  always_comb begin
    ctrl_o = ctrl_raw;
    if (illegal_raw) begin
      ctrl_o.rf_we   = 1'b0;
      ctrl_o.lsu_req = 1'b0;
      ctrl_o.branch  = 1'b0;
      ctrl_o.jump    = 1'b0;
    end
  end

  assign illegal_o = illegal_raw;

endmodule

`default_nettype wire

// ==== id_operand_mux.sv ====
/*
  Immediate extraction and ALU operand selection, combinational.
  B and J immediates are also exported for the PC target adder.
*/
`default_nettype none

module id_operand_mux (
  input  logic [id_pkg::xlen-1:0] instr_i,
  input  logic [id_pkg::xlen-1:0] pc_i,
  input  logic [id_pkg::xlen-1:0] rdata_a_i,
  input  logic [id_pkg::xlen-1:0] rdata_b_i,
  input  id_pkg::ctrl_t           ctrl_i,
  output id_pkg::ex_req_t         ex_req_o,
  output logic [id_pkg::xlen-1:0] imm_b_type_o,
  output logic [id_pkg::xlen-1:0] imm_j_type_o
);
  import id_pkg::*;

  logic [xlen-1:0] imm_i_type;
  logic [xlen-1:0] imm_s_type;
  logic [xlen-1:0] imm_b_type;
  logic [xlen-1:0] imm_u_type;
  logic [xlen-1:0] imm_j_type;
  logic [xlen-1:0] imm;

  ////////////////////
  // Immediates
  ////////////////////

  // All signed formats take their sign from bit 31
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    unique case (ctrl_i.imm_sel)
      imm_sel_itype: imm = imm_i_type;
      imm_sel_stype: imm = imm_s_type;
      imm_sel_btype: imm = imm_b_type;
      imm_sel_utype: imm = imm_u_type;
      imm_sel_jtype: imm = imm_j_type;
      default:       imm = imm_i_type;
    endcase
  end

  ////////////////////
  // Operands
  ////////////////////

  always_comb begin
    ex_req_o.alu_op = ctrl_i.alu_op;
    unique case (ctrl_i.op_a_sel)
      op_a_reg: ex_req_o.operand_a = rdata_a_i;
      op_a_pc:  ex_req_o.operand_a = pc_i;
      default:  ex_req_o.operand_a = '0;
    endcase
    ex_req_o.operand_b = (ctrl_i.op_b_sel == op_b_imm) ? imm : rdata_b_i;
  end

  assign imm_b_type_o = imm_b_type;
  assign imm_j_type_o = imm_j_type;

endmodule

`default_nettype wire

// ==== id_regfile.sv ====
/*
  Flip-flop register file, two async read ports, one write port.
  x0 reads zero and drops writes; a write is visible on the read ports one cycle later.
*/
`default_nettype none

module id_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [id_pkg::reg_addr_w-1:0] raddr_a_i,
  input  logic [id_pkg::reg_addr_w-1:0] raddr_b_i,
  input  logic [id_pkg::reg_addr_w-1:0] waddr_i,
  input  logic                          we_i,
  input  logic [id_pkg::xlen-1:0]       wdata_i,
  output logic [id_pkg::xlen-1:0]       rdata_a_o,
  output logic [id_pkg::xlen-1:0]       rdata_b_o
);
  import id_pkg::*;

  logic [xlen-1:0] rf_q [32];

  // x0 is a constant, never a flop
  assign rf_q[0] = '0;

  for (genvar i = 1; i < 32; i++) begin : g_rf
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_i && (waddr_i == reg_addr_w'(i))) begin
        rf_q[i] <= wdata_i;
      end
    end
  end

  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== id_fsm.sv ====
/*
  First/multi-cycle sequencer; only one instruction is in flight at a time.
  instr_valid_i and ctrl_i must stay stable until instr_done_o.
  Branches resolve in the first cycle from branch_decision_i of that same cycle.
*/
`default_nettype none

module id_fsm (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          instr_valid_i,
  input  id_pkg::ctrl_t ctrl_i,
  input  logic          illegal_i,
  input  logic          branch_decision_i,
  input  logic          lsu_resp_valid_i,
  input  logic          data_ind_timing_i,
  output logic          instr_done_o,
  output logic          lsu_req_o,
  output logic          pc_set_o,
  output logic          branch_taken_o,
  output logic          rf_we_o
);
  import id_pkg::*;

  typedef enum logic {
    first_cycle,
    multi_cycle
  } id_state_e;

  id_state_e state_q, state_d;
  logic      executing;
  logic      stall;
  logic      pc_set_raw;
  logic      set_done_q;
  logic      branch_taken_q;

  // Illegal words pass straight through as done
  assign executing = instr_valid_i & ~illegal_i;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d    = state_q;
    stall      = 1'b0;
    pc_set_raw = 1'b0;

    if (executing) begin
      unique case (state_q)
        first_cycle: begin
          if (ctrl_i.lsu_req) begin
            // Response never counts in the request cycle
            state_d = multi_cycle;
            stall   = 1'b1;
          end else if (ctrl_i.branch) begin
            // DIT mode spends the second cycle even on not-taken branches
            if (data_ind_timing_i || branch_decision_i) begin
              state_d = multi_cycle;
              stall   = 1'b1;
            end
          end else if (ctrl_i.jump) begin
            state_d    = multi_cycle;
            stall      = 1'b1;
            pc_set_raw = 1'b1;
          end
        end

        multi_cycle: begin
          if (ctrl_i.lsu_req) begin
            stall = ~lsu_resp_valid_i;
          end else begin
            // Only branches set the PC here, jumps did it already
            pc_set_raw = ctrl_i.branch;
          end
          if (!stall) begin
            state_d = first_cycle;
          end
        end

        default: state_d = first_cycle;
      endcase
    end
  end

  ////////////////////
  // State and flags
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= first_cycle;
      set_done_q     <= 1'b0;
      branch_taken_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      // Remember a PC set until the instruction retires
      set_done_q <= (pc_set_o | set_done_q) & ~instr_done_o;
      // Decision captured in the first cycle of a branch for DIT mode
      if (executing && (state_q == first_cycle) && ctrl_i.branch) begin
        branch_taken_q <= branch_decision_i;
      end
    end
  end

  assign instr_done_o = instr_valid_i & ~stall;
  assign lsu_req_o    = executing & (state_q == first_cycle) & ctrl_i.lsu_req;
  assign rf_we_o      = instr_done_o & ~illegal_i & ctrl_i.rf_we;
  assign pc_set_o     = pc_set_raw & ~set_done_q;

  // Without DIT only taken branches reach the PC set
  assign branch_taken_o = ~data_ind_timing_i | branch_taken_q;

endmodule

`default_nettype wire

// ==== id_stage.sv ====
/*
  Reduced RV32I decode and issue stage with its own register file.
  Fetch holds the instruction until instr_done_o; execute answers in the same cycle.
  JAL hands pc plus J-immediate to execute and writes back whatever result_ex_i carries.
*/
`default_nettype none

module id_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    instr_valid_i,
  input  logic [id_pkg::xlen-1:0] instr_i,
  input  logic [id_pkg::xlen-1:0] pc_i,
  input  logic                    branch_decision_i,
  input  logic [id_pkg::xlen-1:0] result_ex_i,
  input  logic                    lsu_resp_valid_i,
  input  logic                    data_ind_timing_i,
  output logic                    instr_done_o,
  output logic                    illegal_insn_o,
  output id_pkg::ex_req_t         ex_req_o,
  output id_pkg::lsu_req_t        lsu_req_o,
  output logic                    pc_set_o,
  output logic [id_pkg::xlen-1:0] pc_target_o
);
  import id_pkg::*;

  ctrl_t                 ctrl;
  logic                  illegal;
  logic [reg_addr_w-1:0] raddr_a;
  logic [reg_addr_w-1:0] raddr_b;
  logic [xlen-1:0]       rdata_a;
  logic [xlen-1:0]       rdata_b;
  logic [xlen-1:0]       imm_b_type;
  logic [xlen-1:0]       imm_j_type;
  logic                  rf_we;
  logic                  lsu_req;
  logic                  branch_taken;

  ////////////////////
  // Decode
  ////////////////////

  id_decoder u_decoder (
    .instr_i  (instr_i),
    .ctrl_o   (ctrl),
    .illegal_o(illegal)
  );

  assign illegal_insn_o = illegal & instr_valid_i;

  ////////////////////
  // Register file
  ////////////////////

  // Unused ports read x0 so they stay quiet
  assign raddr_a = ctrl.ren_a ? ctrl.rs1 : '0;
  assign raddr_b = ctrl.ren_b ? ctrl.rs2 : '0;

  id_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a),
    .raddr_b_i(raddr_b),
    .waddr_i  (ctrl.rd),
    .we_i     (rf_we),
    .wdata_i  (result_ex_i),
    .rdata_a_o(rdata_a),
    .rdata_b_o(rdata_b)
  );

  id_operand_mux u_operand_mux (
    .instr_i     (instr_i),
    .pc_i        (pc_i),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .ctrl_i      (ctrl),
    .ex_req_o    (ex_req_o),
    .imm_b_type_o(imm_b_type),
    .imm_j_type_o(imm_j_type)
  );

  ////////////////////
  // Sequencing
  ////////////////////

  id_fsm u_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .ctrl_i           (ctrl),
    .illegal_i        (illegal),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .data_ind_timing_i(data_ind_timing_i),
    .instr_done_o     (instr_done_o),
    .lsu_req_o        (lsu_req),
    .pc_set_o         (pc_set_o),
    .branch_taken_o   (branch_taken),
    .rf_we_o          (rf_we)
  );

  // Store data always comes from rs2
  assign lsu_req_o.req       = lsu_req;
  assign lsu_req_o.we        = ctrl.lsu_we;
  assign lsu_req_o.data_type = ctrl.lsu_type;
  assign lsu_req_o.sign_ext  = ctrl.lsu_sign_ext;
  assign lsu_req_o.wdata     = rdata_b;

  // Not-taken target only shows up on DIT branches
  always_comb begin
    if (ctrl.jump) begin
      pc_target_o = pc_i + imm_j_type;
    end else if (branch_taken) begin
      pc_target_o = pc_i + imm_b_type;
    end else begin
      pc_target_o = pc_i + pc_incr;
    end
  end

endmodule

`default_nettype wire

// ==== tb_id_model.svh ====
/*
  Reference model of the decode stage, included inside the testbench module.
  The including scope must import id_pkg; only RV32I words kept by the stage are legal.
*/
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// Timing class of an instruction
typedef enum logic [2:0] {
  kind_alu,
  kind_mem,
  kind_branch,
  kind_jal,
  kind_illegal
} insn_kind_e;

// Expected response to one instruction word
typedef struct packed {
  insn_kind_e kind;
  logic       illegal;
  logic       rf_we;
  ex_req_t    ex;
  lsu_req_t   lsu;
} expect_t;

////////////////////
// Immediates
////////////////////

function automatic logic [31:0] sext_i_imm(input logic [31:0] w);
  return 32'($signed(w[31:20]));
endfunction

function automatic logic [31:0] store_imm(input logic [31:0] w);
  return 32'($signed({w[31:25], w[11:7]}));
endfunction

function automatic logic [31:0] branch_offset(input logic [31:0] w);
  return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
endfunction

function automatic logic [31:0] upper_imm(input logic [31:0] w);
  return {w[31:12], 12'h000};
endfunction

function automatic logic [31:0] jump_offset(input logic [31:0] w);
  return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
endfunction

////////////////////
// Decode
////////////////////

// Register and immediate ALU ops share funct3, alt picks sub or sra
function automatic alu_op_e alu_for_funct3(input logic [2:0] f3, input logic alt);
  alu_op_e op;
  case (f3)
    3'b000:  op = alt ? alu_sub : alu_add;
    3'b001:  op = alu_sll;
    3'b010:  op = alu_slt;
    3'b011:  op = alu_sltu;
    3'b100:  op = alu_xor;
    3'b101:  op = alt ? alu_sra : alu_srl;
    3'b110:  op = alu_or;
    default: op = alu_and;
  endcase
  return op;
endfunction

function automatic alu_op_e branch_cmp(input logic [2:0] f3);
  alu_op_e op;
  case (f3)
    3'b000:  op = alu_eq;
    3'b001:  op = alu_ne;
    3'b100:  op = alu_lt;
    3'b101:  op = alu_ge;
    3'b110:  op = alu_ltu;
    default: op = alu_geu;
  endcase
  return op;
endfunction

// ra and rb are the model register values of rs1 and rs2
function automatic expect_t expected_for(input logic [31:0] w, input logic [31:0] pc,
                                         input logic [31:0] ra, input logic [31:0] rb);
  expect_t    e;
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = w[14:12];
  f7 = w[31:25];
  e = '0;
  e.kind = kind_illegal;
  e.ex.alu_op = alu_add;
  e.lsu.data_type = lsu_word;
  case (w[6:0])
    7'h33: begin
      // Only add/sub and srl/sra have an alternate funct7
      if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
        e.kind  = kind_alu;
        e.rf_we = 1'b1;
        e.ex    = '{alu_for_funct3(f3, f7[5]), ra, rb};
      end
    end
    7'h13: begin
      if (!(f3 == 3'b001 && f7 != 7'h00) &&
          !(f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20)) begin
        e.kind  = kind_alu;
        e.rf_we = 1'b1;
        e.ex    = '{alu_for_funct3(f3, (f3 == 3'b101) && f7[5]), ra, sext_i_imm(w)};
      end
    end
    7'h37: begin
      e.kind  = kind_alu;
      e.rf_we = 1'b1;
      e.ex    = '{alu_add, 32'h0, upper_imm(w)};
    end
    7'h17: begin
      e.kind  = kind_alu;
      e.rf_we = 1'b1;
      e.ex    = '{alu_add, pc, upper_imm(w)};
    end
    7'h03: begin
      // lb, lh, lw, lbu, lhu
      if (f3[1:0] != 2'b11 && !(f3[2] && f3[1])) begin
        e.kind         = kind_mem;
        e.rf_we        = 1'b1;
        e.ex           = '{alu_add, ra, sext_i_imm(w)};
        e.lsu.req      = 1'b1;
        e.lsu.sign_ext = ~f3[2];
        e.lsu.data_type = (f3[1:0] == 2'b00) ? lsu_byte :
                          (f3[1:0] == 2'b01) ? lsu_half : lsu_word;
      end
    end
    7'h23: begin
      if (f3 < 3'd3) begin
        e.kind      = kind_mem;
        e.ex        = '{alu_add, ra, store_imm(w)};
        e.lsu.req   = 1'b1;
        e.lsu.we    = 1'b1;
        e.lsu.wdata = rb;
        e.lsu.data_type = (f3 == 3'b000) ? lsu_byte : (f3 == 3'b001) ? lsu_half : lsu_word;
      end
    end
    7'h63: begin
      if (f3[2:1] != 2'b01) begin
        e.kind = kind_branch;
        e.ex   = '{branch_cmp(f3), ra, rb};
      end
    end
    7'h6f: begin
      e.kind  = kind_jal;
      e.rf_we = 1'b1;
      e.ex    = '{alu_add, pc, jump_offset(w)};
    end
    default: e.kind = kind_illegal;
  endcase
  e.illegal = (e.kind == kind_illegal);
  return e;
endfunction

`endif

// ==== tb_id_stage.sv ====
/*
  Random instruction testbench; execute and LSU are played by the testbench.
  Inputs change 1 unit after the rising edge and outputs are compared on the falling edge.
*/
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  `include "tb_id_model.svh"

  localparam int unsigned n_instr     = 400;
  // Worst case is a load with 4 wait states and an idle cycle before it
  localparam int unsigned cycle_limit = 20 * n_instr + 50;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            instr_valid_i;
  logic [xlen-1:0] instr_i;
  logic [xlen-1:0] pc_i;
  logic            branch_decision_i;
  logic [xlen-1:0] result_ex_i;
  logic            lsu_resp_valid_i;
  logic            data_ind_timing_i;
  logic            instr_done_o;
  logic            illegal_insn_o;
  ex_req_t         ex_req_o;
  lsu_req_t        lsu_req_o;
  logic            pc_set_o;
  logic [xlen-1:0] pc_target_o;

  // Architectural registers as the testbench expects them
  logic [xlen-1:0] model_rf [32];
  int unsigned     cur_cyc   = 0;
  int unsigned     lsu_delay = 1;
  int unsigned     err_cnt   = 0;
  int unsigned     check_cnt = 0;
  int unsigned     cycle_cnt = 0;
  // Branch decision that execute gave in cycle 0
  logic            taken_first = 1'b0;

  id_stage u_id_stage (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .pc_i             (pc_i),
    .branch_decision_i(branch_decision_i),
    .result_ex_i      (result_ex_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .data_ind_timing_i(data_ind_timing_i),
    .instr_done_o     (instr_done_o),
    .illegal_insn_o   (illegal_insn_o),
    .ex_req_o         (ex_req_o),
    .lsu_req_o        (lsu_req_o),
    .pc_set_o         (pc_set_o),
    .pc_target_o      (pc_target_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic log_mismatch(input string name, input logic [68:0] got,
                              input logic [68:0] exp);
    $display("error: time %0t, %s got %0h expected %0h", $time, name, got, exp);
    err_cnt++;
  endtask

  // Registers come from x0 to x7 so that writes are read back often
  function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(7));
  endfunction

  function automatic logic [31:0] make_instr();
    logic [31:0] w;
    logic [31:0] r;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    r   = $urandom();
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    f3  = 3'($urandom_range(7));
    case ($urandom_range(8))
      0: w = {((f3 == 3'b000 || f3 == 3'b101) && r[0]) ? 7'h20 : 7'h00,
              rs2, rs1, f3, rd, 7'h33};
      1: begin
        imm = r[31:20];
        if (f3 == 3'b001) imm[11:5] = 7'h00;
        if (f3 == 3'b101) imm[11:5] = r[0] ? 7'h20 : 7'h00;
        w = {imm, rs1, f3, rd, 7'h13};
      end
      2: w = {r[31:12], rd, 7'h37};
      3: w = {r[31:12], rd, 7'h17};
      4: begin
        // Map 0..4 onto lb, lh, lw, lbu, lhu
        f3 = 3'($urandom_range(4));
        if (f3 >= 3'd3) f3 = f3 + 3'd1;
        w = {r[31:20], rs1, f3, rd, 7'h03};
      end
      5: w = {r[31:25], rs2, rs1, 3'($urandom_range(2)), r[11:7], 7'h23};
      6: begin
        // Skip the two reserved branch funct3 codes
        f3 = 3'($urandom_range(5));
        if (f3 >= 3'd2) f3 = f3 + 3'd2;
        w = {r[31:25], rs2, rs1, f3, r[11:7], 7'h63};
      end
      7: w = {r[31:12], rd, 7'h6f};
      default: begin
        case ($urandom_range(6))
          0: w = {r[31:7], 7'h67};
          1: w = {r[31:7], 7'h0f};
          2: w = {r[31:7], 7'h73};
          3: w = {7'h01, rs2, rs1, f3, rd, 7'h33};
          4: w = {r[31:25], rs2, rs1, 2'b01, r[12], r[11:7], 7'h63};
          5: w = {r[31:25], rs2, rs1, 3'($urandom_range(7, 3)), r[11:7], 7'h23};
          default: w = {r[31:2], 2'b01};
        endcase
      end
    endcase
    return w;
  endfunction

  ////////////////////
  // Fetch, execute and LSU side
  ////////////////////

  initial begin : drive
    int unsigned n;
    logic        done;
    logic        is_mem;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_i              = '0;
    branch_decision_i = 1'b0;
    result_ex_i       = '0;
    lsu_resp_valid_i  = 1'b0;
    data_ind_timing_i = 1'b0;
    void'($urandom(32'h60bd5581));
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (n = 0; n < n_instr; n++) begin
      @(posedge clk_i);
      #1;
      // Fetch sometimes leaves a bubble
      if ($urandom_range(3) == 0) begin
        instr_valid_i    = 1'b0;
        lsu_resp_valid_i = 1'b0;
        @(posedge clk_i);
        #1;
      end
      instr_i           = make_instr();
      pc_i              = $urandom() & 32'hffff_fffc;
      branch_decision_i = 1'($urandom_range(1));
      taken_first       = branch_decision_i;
      data_ind_timing_i = 1'($urandom_range(1));
      result_ex_i       = $urandom();
      lsu_delay         = $urandom_range(4, 1);
      lsu_resp_valid_i  = 1'b0;
      cur_cyc           = 0;
      instr_valid_i     = 1'b1;
      is_mem            = (instr_i[6:0] == 7'h03) || (instr_i[6:0] == 7'h23);
      done              = 1'b0;
      // Hold the instruction until the stage reports done
      while (!done) begin
        @(negedge clk_i);
        done = instr_done_o;
        if (!done) begin
          @(posedge clk_i);
          #1;
          cur_cyc++;
          lsu_resp_valid_i = is_mem && (cur_cyc == lsu_delay);
          // Only the cycle 0 decision counts and later values are noise
          branch_decision_i = 1'($urandom_range(1));
        end
      end
    end
    @(posedge clk_i);
    #1;
    instr_valid_i    = 1'b0;
    lsu_resp_valid_i = 1'b0;
    repeat (3) @(posedge clk_i);
    $display("summary: %0d instructions, %0d cycles checked, %0d errors",
             n_instr, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  ////////////////////
  // Comparison
  ////////////////////

  always @(negedge clk_i) begin : compare
    expect_t         e;
    logic            exp_done;
    logic            exp_set;
    logic            exp_req;
    logic [xlen-1:0] exp_tgt;
    if (!rst_ni) begin
      foreach (model_rf[i]) begin
        model_rf[i] = '0;
      end
    end else if (!instr_valid_i) begin
      // Nothing may fire in a bubble
      if (instr_done_o !== 1'b0) log_mismatch("instr_done_o", 69'(instr_done_o), 69'(0));
      if (pc_set_o !== 1'b0) log_mismatch("pc_set_o", 69'(pc_set_o), 69'(0));
      if (lsu_req_o.req !== 1'b0) log_mismatch("lsu_req_o.req", 69'(lsu_req_o.req), 69'(0));
      if (illegal_insn_o !== 1'b0) log_mismatch("illegal_insn_o", 69'(illegal_insn_o), 69'(0));
    end else begin
      check_cnt++;
      e = expected_for(instr_i, pc_i, model_rf[instr_i[19:15]], model_rf[instr_i[24:20]]);
      exp_set = 1'b0;
      exp_tgt = pc_i + 32'd4;
      case (e.kind)
        // Done comes exactly with the LSU strobe and never in cycle 0
        kind_mem: exp_done = lsu_resp_valid_i;
        kind_jal: begin
          exp_set  = (cur_cyc == 0);
          exp_done = (cur_cyc == 1);
          exp_tgt  = pc_i + jump_offset(instr_i);
        end
        kind_branch: begin
          if (data_ind_timing_i || taken_first) begin
            exp_set  = (cur_cyc == 1);
            exp_done = (cur_cyc == 1);
            if (taken_first) exp_tgt = pc_i + branch_offset(instr_i);
          end else begin
            exp_done = (cur_cyc == 0);
          end
        end
        default: exp_done = (cur_cyc == 0);
      endcase
      exp_req = e.lsu.req && (cur_cyc == 0);

      if (illegal_insn_o !== e.illegal) begin
        log_mismatch("illegal_insn_o", 69'(illegal_insn_o), 69'(e.illegal));
      end
      if (!e.illegal && ex_req_o !== e.ex) begin
        log_mismatch("ex_req_o", 69'(ex_req_o), 69'(e.ex));
      end
      if (instr_done_o !== exp_done) begin
        log_mismatch("instr_done_o", 69'(instr_done_o), 69'(exp_done));
      end
      if (pc_set_o !== exp_set) log_mismatch("pc_set_o", 69'(pc_set_o), 69'(exp_set));
      if (exp_set && pc_target_o !== exp_tgt) begin
        log_mismatch("pc_target_o", 69'(pc_target_o), 69'(exp_tgt));
      end
      if (lsu_req_o.req !== exp_req) begin
        log_mismatch("lsu_req_o.req", 69'(lsu_req_o.req), 69'(exp_req));
      end
      // Request attributes only matter while req is up
      if (exp_req && lsu_req_o.we !== e.lsu.we) begin
        log_mismatch("lsu_req_o.we", 69'(lsu_req_o.we), 69'(e.lsu.we));
      end
      if (exp_req && lsu_req_o.data_type !== e.lsu.data_type) begin
        log_mismatch("lsu_req_o.data_type", 69'(lsu_req_o.data_type), 69'(e.lsu.data_type));
      end
      if (exp_req && lsu_req_o.sign_ext !== e.lsu.sign_ext) begin
        log_mismatch("lsu_req_o.sign_ext", 69'(lsu_req_o.sign_ext), 69'(e.lsu.sign_ext));
      end
      if (exp_req && e.lsu.we && lsu_req_o.wdata !== e.lsu.wdata) begin
        log_mismatch("lsu_req_o.wdata", 69'(lsu_req_o.wdata), 69'(e.lsu.wdata));
      end

      // Write-back at done leaves x0 at zero
      if (exp_done && e.rf_we && instr_i[11:7] != 5'd0) begin
        model_rf[instr_i[11:7]] = result_ex_i;
      end
    end
  end

  ////////////////////
  // Timeout
  ////////////////////

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
id_pkg.sv
id_decoder.sv
id_operand_mux.sv
id_regfile.sv
id_fsm.sv
id_stage.sv
tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_STR  ?= TEST OK

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) tb_id_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
